/* mips_core.f */
+incdir+hdl
hdl/mips_core_pkg.sv
hdl/fetch_stage.sv
hdl/id.sv
hdl/regfile.sv
hdl/ex_stage.sv
hdl/mips_core.sv
sim/mips_core_assertions.sv
sim/mips_core_checker.sv
sim/mips_core_tb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_core_pkg.sv
      - hdl/fetch_stage.sv
      - hdl/id.sv
      - hdl/regfile.sv
      - hdl/ex_stage.sv
      - hdl/mips_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/mips_core_assertions.sv
      - sim/mips_core_checker.sv
      - sim/mips_core_tb.sv

/* sim/mips_core_tb.sv */
// ******************************
// clock, reset, instruction rom,
// test programs and timeout
// ******************************
`include "mips_core_config.svh"

module mips_core_tb import mips_core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS = 5;
    localparam int RAND_LEN = 200;

    // function codes the random program draws from, sync last
    localparam logic [5:0] FN_TABLE [17] = '{
        `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV,
        `FN_SRLV, `FN_SRAV, `FN_MFHI, `FN_MFLO, `FN_MTHI, `FN_MTLO, `FN_MOVN,
        `FN_MOVZ, `FN_SYNC
    };

    logic         clk;
    logic         rst_n;
    inst_t        inst;
    logic         inst_ce;
    word_t        inst_addr;
    logic         wb_we;
    reg_addr_t    wb_addr;
    word_t        wb_data;
    logic         test_done;
    logic [127:0] test_name;
    int           pass_cnt;
    int           fail_cnt;

    // all programs back to back in one store
    inst_t        prog_mem [512];
    int           prog_start [N_TESTS];
    int           prog_len [N_TESTS];
    int           prog_top;
    int           cur_test;
    integer       seed;
    int           cycle_cnt;
    int           cycle_limit;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    mips_core i_mips_core (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .inst_i      (inst),
        .inst_ce_o   (inst_ce),
        .inst_addr_o (inst_addr),
        .wb_we_o     (wb_we),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data)
    );

    mips_core_checker i_checker (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .inst_ce_i   (inst_ce),
        .inst_i      (inst),
        .wb_we_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .test_done_i (test_done),
        .test_name_i (test_name),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    // rom read, zero past the end of the program
    always @(posedge clk) begin
        #1;
        if (int'(inst_addr[31:2]) < prog_len[cur_test]) begin
            inst = prog_mem[prog_start[cur_test] + int'(inst_addr[31:2])];
        end else begin
            inst = '0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic inst_t itype(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic inst_t rtype(input logic [5:0] fn, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input reg_addr_t sa);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    // random fields, then opcode or function forced into the subset
    function automatic inst_t random_inst();
        inst_t w;
        int    k;
        w = $random(seed);
        k = $unsigned($random(seed)) % 24;
        case (k)
            0:       w[31:26] = `OP_ORI;
            1:       w[31:26] = `OP_ANDI;
            2:       w[31:26] = `OP_XORI;
            3:       w[31:26] = `OP_LUI;
            4:       w[31:26] = `OP_PREF;
            5:       w[31:26] = 6'b011011;
            6:       w[31:26] = 6'b111101;
            default: begin
                w[31:26] = `OP_SPECIAL;
                w[5:0]   = FN_TABLE[k - 7];
            end
        endcase
        return w;
    endfunction

    task automatic emit(input inst_t w);
        prog_mem[prog_top] = w;
        prog_top++;
    endtask

    task automatic build_programs();
        prog_top = 0;
        // immediate chains at distance 1, 2, 3 and beyond
        prog_start[0] = prog_top;
        emit(itype(`OP_ORI, 0, 1, 16'h1234));
        emit(itype(`OP_ORI, 1, 1, 16'h00f0));
        emit(itype(`OP_ANDI, 1, 2, 16'h0ff0));
        emit(itype(`OP_XORI, 1, 3, 16'hffff));
        emit(itype(`OP_LUI, 0, 4, 16'hdead));
        emit(itype(`OP_ORI, 2, 5, 16'h0001));
        emit(itype(`OP_ORI, 4, 4, 16'hbeef));
        emit(itype(`OP_XORI, 4, 6, 16'h5555));
        emit(itype(`OP_ANDI, 3, 7, 16'haaaa));
        emit(itype(`OP_LUI, 0, 1, 16'hffff));
        emit(itype(`OP_XORI, 1, 1, 16'hffff));
        prog_len[0] = prog_top - prog_start[0];
        // register logic, all-ones and zero operands
        prog_start[1] = prog_top;
        emit(itype(`OP_ORI, 0, 1, 16'hffff));
        emit(itype(`OP_LUI, 0, 2, 16'hffff));
        emit(itype(`OP_ORI, 2, 2, 16'hffff));
        emit(itype(`OP_ORI, 0, 3, 16'h0000));
        emit(itype(`OP_LUI, 0, 4, 16'ha5a5));
        emit(itype(`OP_ORI, 4, 4, 16'h5a5a));
        emit(rtype(`FN_AND, 2, 4, 5, 0));
        emit(rtype(`FN_OR, 3, 4, 6, 0));
        emit(rtype(`FN_XOR, 2, 4, 7, 0));
        emit(rtype(`FN_NOR, 3, 3, 8, 0));
        emit(rtype(`FN_NOR, 2, 1, 9, 0));
        emit(rtype(`FN_AND, 4, 3, 10, 0));
        emit(rtype(`FN_XOR, 5, 7, 11, 0));
        emit(rtype(`FN_OR, 1, 2, 12, 0));
        prog_len[1] = prog_top - prog_start[1];
        // r1 negative, r2 = 36 and r3 = -29 as shift amounts
        prog_start[2] = prog_top;
        emit(itype(`OP_LUI, 0, 1, 16'h8000));
        emit(itype(`OP_ORI, 1, 1, 16'h00f1));
        emit(itype(`OP_ORI, 0, 2, 16'h0024));
        emit(itype(`OP_LUI, 0, 3, 16'hffff));
        emit(itype(`OP_ORI, 3, 3, 16'hffe3));
        emit(rtype(`FN_SLL, 0, 1, 4, 4));
        emit(rtype(`FN_SRL, 0, 1, 5, 31));
        emit(rtype(`FN_SRA, 0, 1, 6, 8));
        emit(rtype(`FN_SRA, 0, 1, 7, 0));
        emit(rtype(`FN_SLL, 0, 1, 8, 31));
        emit(rtype(`FN_SLLV, 2, 1, 9, 0));
        emit(rtype(`FN_SRLV, 3, 1, 10, 0));
        emit(rtype(`FN_SRAV, 2, 1, 11, 0));
        emit(rtype(`FN_SRAV, 3, 1, 12, 0));
        emit(itype(`OP_ORI, 0, 13, 16'h7000));
        emit(rtype(`FN_SRAV, 3, 13, 14, 0));
        prog_len[2] = prog_top - prog_start[2];
        // hi/lo, conditional moves and r0 targets
        prog_start[3] = prog_top;
        emit(itype(`OP_ORI, 0, 1, 16'h1111));
        emit(itype(`OP_LUI, 0, 2, 16'h2222));
        emit(rtype(`FN_MTHI, 1, 0, 0, 0));
        emit(rtype(`FN_MFHI, 0, 0, 3, 0));
        emit(rtype(`FN_MTLO, 2, 0, 0, 0));
        emit(rtype(`FN_MFLO, 0, 0, 4, 0));
        emit(itype(`OP_ORI, 0, 5, 16'h0000));
        emit(itype(`OP_ORI, 0, 6, 16'h0007));
        emit(rtype(`FN_MOVN, 1, 6, 7, 0));
        emit(rtype(`FN_MOVN, 1, 5, 8, 0));
        emit(rtype(`FN_MOVZ, 2, 5, 9, 0));
        emit(rtype(`FN_MOVZ, 2, 6, 10, 0));
        emit(rtype(`FN_MOVN, 2, 6, 6, 0));
        emit(rtype(`FN_MOVZ, 1, 5, 5, 0));
        emit(itype(`OP_ORI, 1, 0, 16'h0055));
        emit(rtype(`FN_OR, 0, 0, 11, 0));
        emit(rtype(`FN_MFHI, 0, 0, 0, 0));
        emit(rtype(`FN_MOVN, 1, 6, 0, 0));
        emit(rtype(`FN_OR, 1, 2, 0, 0));
        emit(itype(`OP_ORI, 0, 12, 16'h0000));
        emit(rtype(`FN_SLL, 0, 0, 13, 0));
        emit(itype(`OP_ORI, 0, 15, 16'h0000));
        emit(rtype(`FN_MOVZ, 1, 15, 14, 0));
        prog_len[3] = prog_top - prog_start[3];
        // every register gets a value before the random part reads it
        prog_start[4] = prog_top;
        for (int r = 1; r < `REG_NUM; r++) begin
            emit(itype(`OP_ORI, 0, reg_addr_t'(r), 16'($random(seed))));
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            emit(random_inst());
        end
        prog_len[4] = prog_top - prog_start[4];
    endtask

    task automatic run_test(input int idx, input logic [127:0] name);
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        cur_test = idx;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (prog_len[idx] + 8) @(posedge clk);
        #1;
        test_name = name;
        test_done = 1'b1;
        @(posedge clk);
        #1;
        test_done = 1'b0;
    endtask

    initial begin
        int assert_fails;
        rst_n = 1'b0;
        inst = '0;
        test_done = 1'b0;
        test_name = '0;
        cur_test = 0;
        cycle_cnt = 0;
        seed = 26;
        build_programs();
        cycle_limit = 50;
        for (int t = 0; t < N_TESTS; t++) begin
            cycle_limit += 16 + prog_len[t] + 8;
        end
        run_test(0, "imm_chain");
        run_test(1, "reg_logic");
        run_test(2, "shifts");
        run_test(3, "hilo_moves");
        run_test(4, "random_mix");
        assert_fails = i_mips_core.i_mips_core_assertions.fail_count;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 pass_cnt, fail_cnt, assert_fails);
        if (pass_cnt == N_TESTS && fail_cnt == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim/mips_core_checker.sv */
// ******************************
// reference model of the register
// writes and in-order comparison
// ******************************
`include "mips_core_config.svh"

module mips_core_checker import mips_core_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         inst_ce_i,
    input  inst_t        inst_i,
    input  logic         wb_we_i,
    input  reg_addr_t    wb_addr_i,
    input  word_t        wb_data_i,
    input  logic         test_done_i,
    input  logic [127:0] test_name_i,
    output int           pass_cnt_o,
    output int           fail_cnt_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // architectural state
    word_t       model_regs [`REG_NUM];
    word_t       model_hi;
    word_t       model_lo;

    // expected writes as {addr, data}
    logic [36:0] expect_q [$];
    logic [36:0] head;
    logic [36:0] first_exp;
    logic [36:0] first_act;
    reg_addr_t   exp_addr;
    word_t       exp_data;
    int          mismatches;
    int          extras;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
    end

    // one instruction against the model, returns 1 when it writes a register
    function automatic logic predict_write(input inst_t inst, output reg_addr_t wa,
                                           output word_t wv);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [15:0] imm;
        word_t       a;
        word_t       b;
        logic        we;
        op  = inst[31:26];
        fn  = inst[5:0];
        sa  = inst[10:6];
        imm = inst[15:0];
        a   = model_regs[inst[25:21]];
        b   = model_regs[inst[20:16]];
        we  = 1'b1;
        wv  = '0;
        wa  = (op == `OP_SPECIAL) ? inst[15:11] : inst[20:16];
        case (op)
            `OP_ORI:  wv = a | {16'h0, imm};
            `OP_ANDI: wv = a & {16'h0, imm};
            `OP_XORI: wv = a ^ {16'h0, imm};
            `OP_LUI:  wv = {imm, 16'h0};
            `OP_SPECIAL: begin
                case (fn)
                    `FN_AND:  wv = a & b;
                    `FN_OR:   wv = a | b;
                    `FN_XOR:  wv = a ^ b;
                    `FN_NOR:  wv = ~(a | b);
                    `FN_SLL:  wv = b << sa;
                    `FN_SRL:  wv = b >> sa;
                    `FN_SRA:  wv = $signed(b) >>> sa;
                    `FN_SLLV: wv = b << a[4:0];
                    `FN_SRLV: wv = b >> a[4:0];
                    `FN_SRAV: wv = $signed(b) >>> a[4:0];
                    `FN_MFHI: wv = model_hi;
                    `FN_MFLO: wv = model_lo;
                    `FN_MTHI: begin
                        model_hi = a;
                        we = 1'b0;
                    end
                    `FN_MTLO: begin
                        model_lo = a;
                        we = 1'b0;
                    end
                    `FN_MOVN: begin
                        wv = a;
                        we = (b != '0);
                    end
                    `FN_MOVZ: begin
                        wv = a;
                        we = (b == '0);
                    end
                    default:  we = 1'b0;
                endcase
            end
            default: we = 1'b0;
        endcase
        // r0 is hardwired, so a write there is no write at all
        we = we && (wa != '0);
        if (we) begin
            model_regs[wa] = wv;
        end
        return we;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        model_hi = '0;
        model_lo = '0;
        expect_q.delete();
        mismatches = 0;
        extras = 0;
    endtask

    task automatic report_test();
        if (mismatches != 0) begin
            $display("ERR %0s: expected r%0d = %08h, actual r%0d = %08h, %0d bad writes",
                     test_name_i, first_exp[36:32], first_exp[31:0],
                     first_act[36:32], first_act[31:0], mismatches);
        end else if (extras != 0) begin
            $display("%0s: %0d register writes appeared that no instruction called for",
                     test_name_i, extras);
        end else if (expect_q.size() != 0) begin
            $display("%0s: %0d expected register writes never appeared",
                     test_name_i, expect_q.size());
        end else begin
            $display("%0s: test passed", test_name_i);
        end
        if (mismatches == 0 && extras == 0 && expect_q.size() == 0) begin
            pass_cnt_o++;
        end else begin
            fail_cnt_o++;
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            clear_model();
        end else begin
            // compare the retiring write before queueing the new fetch
            if (wb_we_i) begin
                if (expect_q.size() == 0) begin
                    extras++;
                end else begin
                    head = expect_q.pop_front();
                    if (head !== {wb_addr_i, wb_data_i}) begin
                        if (mismatches == 0) begin
                            first_exp = head;
                            first_act = {wb_addr_i, wb_data_i};
                        end
                        mismatches++;
                    end
                end
            end
            if (inst_ce_i && predict_write(inst_i, exp_addr, exp_data)) begin
                expect_q.push_back({exp_addr, exp_data});
            end
        end
        if (test_done_i) begin
            report_test();
        end
    end

endmodule

/* sim/mips_core_assertions.sv */
// ******************************
// concurrent checks on the core
// ports, bound to mips_core
// ******************************
module mips_core_assertions import mips_core_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      inst_ce_i,
    input word_t     inst_addr_i,
    input logic      wb_we_i,
    input reg_addr_t wb_addr_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench top at the end of the run
    int fail_count = 0;

    // outputs quiet one cycle after a reset edge
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !wb_we_i && !inst_ce_i)
        else begin
            fail_count++;
            $error("write strobe or fetch enable still high after reset");
        end

    no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  !(wb_we_i && wb_addr_i == '0))
        else begin
            fail_count++;
            $error("write-back strobe aimed at r0");
        end

    // pc steps by one word on every fetch
    pc_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                              $past(inst_ce_i) |-> inst_addr_i == $past(inst_addr_i) + 32'd4)
        else begin
            fail_count++;
            $error("fetch address did not advance by 4");
        end

endmodule

bind mips_core mips_core_assertions i_mips_core_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .inst_ce_i   (inst_ce_o),
    .inst_addr_i (inst_addr_o),
    .wb_we_i     (wb_we_o),
    .wb_addr_i   (wb_addr_o)
);

/* hdl/mips_core.sv */
// ******************************
// five-stage core top level
// ******************************
module mips_core import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  inst_t     inst_i,
    output logic      inst_ce_o,
    output word_t     inst_addr_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    inst_t     if_inst;
    logic      reg1_read, reg2_read;
    reg_addr_t reg1_addr, reg2_addr;
    word_t     reg1_data, reg2_data;
    alu_op_e   alu_op;
    alu_sel_e  alu_sel;
    word_t     operand1, operand2;
    reg_addr_t dest_addr;
    logic      dest_we;
    // forwarding paths back into decode
    logic      ex_wreg, mem_wreg;
    word_t     ex_wdata, mem_wdata;
    reg_addr_t ex_wd, mem_wd;

    fetch_stage i_fetch_stage (
        .clk_i, .rst_n_i, .inst_i, .inst_ce_o, .inst_addr_o,
        .if_inst_o (if_inst)
    );

    id i_id (
        .clk_i, .rst_n_i,
        .if_inst_i (if_inst),
        .reg1_data_i (reg1_data), .reg2_data_i (reg2_data),
        .ex_wreg_i (ex_wreg), .ex_wdata_i (ex_wdata), .ex_wd_i (ex_wd),
        .mem_wreg_i (mem_wreg), .mem_wdata_i (mem_wdata), .mem_wd_i (mem_wd),
        .reg1_read_o (reg1_read), .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr), .reg2_addr_o (reg2_addr),
        .alu_op_o (alu_op), .alu_sel_o (alu_sel),
        .operand1_o (operand1), .operand2_o (operand2),
        .dest_addr_o (dest_addr), .dest_we_o (dest_we)
    );

    regfile i_regfile (
        .clk_i, .rst_n_i,
        .reg1_read_i (reg1_read), .reg2_read_i (reg2_read),
        .reg1_addr_i (reg1_addr), .reg2_addr_i (reg2_addr),
        .mem_wreg_i (mem_wreg), .mem_wd_i (mem_wd), .mem_wdata_i (mem_wdata),
        .reg1_data_o (reg1_data), .reg2_data_o (reg2_data),
        .wb_we_o, .wb_addr_o, .wb_data_o
    );

    ex_stage i_ex_stage (
        .clk_i, .rst_n_i,
        .alu_op_i (alu_op), .alu_sel_i (alu_sel),
        .operand1_i (operand1), .operand2_i (operand2),
        .dest_addr_i (dest_addr), .dest_we_i (dest_we),
        .ex_wreg_o (ex_wreg), .ex_wdata_o (ex_wdata), .ex_wd_o (ex_wd),
        .mem_wreg_o (mem_wreg), .mem_wdata_o (mem_wdata), .mem_wd_o (mem_wd)
    );

endmodule

/* hdl/ex_stage.sv */
// ******************************
// logic, shift and move unit, hi/lo
// and execute/memory register
// ******************************
module ex_stage import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  alu_op_e   alu_op_i,
    input  alu_sel_e  alu_sel_i,
    input  word_t     operand1_i,
    input  word_t     operand2_i,
    input  reg_addr_t dest_addr_i,
    input  logic      dest_we_i,
    output logic      ex_wreg_o,
    output word_t     ex_wdata_o,
    output reg_addr_t ex_wd_o,
    output logic      mem_wreg_o,
    output word_t     mem_wdata_o,
    output reg_addr_t mem_wd_o
);

    word_t      hi, lo;
    word_t      logic_res, shift_res, move_res;
    logic [4:0] shamt;

    // only the low five bits of rs or sa count
    assign shamt = operand1_i[4:0];

    always_comb begin
        case (alu_op_i)
            alu_or:  logic_res = operand1_i | operand2_i;
            alu_and: logic_res = operand1_i & operand2_i;
            alu_xor: logic_res = operand1_i ^ operand2_i;
            alu_nor: logic_res = ~(operand1_i | operand2_i);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            alu_sll: shift_res = operand2_i << shamt;
            alu_srl: shift_res = operand2_i >> shamt;
            alu_sra: shift_res = word_t'($signed(operand2_i) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    // movn/movz condition was already settled in decode
    always_comb begin
        case (alu_op_i)
            alu_mfhi:           move_res = hi;
            alu_mflo:           move_res = lo;
            alu_movn, alu_movz: move_res = operand1_i;
            default:            move_res = '0;
        endcase
    end

    always_comb begin
        case (alu_sel_i)
            res_logic: ex_wdata_o = logic_res;
            res_shift: ex_wdata_o = shift_res;
            res_move:  ex_wdata_o = move_res;
            default:   ex_wdata_o = '0;
        endcase
    end

    assign ex_wreg_o = dest_we_i;
    assign ex_wd_o   = dest_addr_i;

    // hi/lo written as mthi/mtlo leaves execute
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (alu_op_i == alu_mthi) begin
                hi <= operand1_i;
            end
            if (alu_op_i == alu_mtlo) begin
                lo <= operand1_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_wreg_o <= 1'b0;
        end else begin
            mem_wreg_o <= ex_wreg_o;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_wdata_o <= ex_wdata_o;
        mem_wd_o    <= ex_wd_o;
    end

endmodule

/* hdl/regfile.sv */
// ******************************
// register file, mem/wb register
// and write-back with bypass
// ******************************
`include "mips_core_config.svh"

module regfile import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      reg1_read_i,
    input  logic      reg2_read_i,
    input  reg_addr_t reg1_addr_i,
    input  reg_addr_t reg2_addr_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     reg1_data_o,
    output word_t     reg2_data_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t regs [`REG_NUM];

    // memory/write-back register, writes to r0 dropped here
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= mem_wreg_i && (mem_wd_i != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= mem_wd_i;
        wb_data_o <= mem_wdata_i;
    end

    // commit
    always_ff @(posedge clk_i) begin
        if (wb_we_o) begin
            regs[wb_addr_o] <= wb_data_o;
        end
    end

    // pending write-back wins over the array, covers distance 3
    function automatic word_t read_port(input logic read, input reg_addr_t addr);
        word_t res;
        if (!read || addr == '0) begin
            res = '0;
        end else if (wb_we_o && wb_addr_o == addr) begin
            res = wb_data_o;
        end else begin
            res = regs[addr];
        end
        return res;
    endfunction

    assign reg1_data_o = read_port(reg1_read_i, reg1_addr_i);
    assign reg2_data_o = read_port(reg2_read_i, reg2_addr_i);

endmodule

/* hdl/id.sv */
// ******************************
// instruction decode, operand
// forwarding, decode/execute reg
// ******************************
`include "mips_core_config.svh"

module id import mips_core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  inst_t     if_inst_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    input  logic      ex_wreg_i,
    input  word_t     ex_wdata_i,
    input  reg_addr_t ex_wd_i,
    input  logic      mem_wreg_i,
    input  word_t     mem_wdata_i,
    input  reg_addr_t mem_wd_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output alu_op_e   alu_op_o,
    output alu_sel_e  alu_sel_o,
    output word_t     operand1_o,
    output word_t     operand2_o,
    output reg_addr_t dest_addr_o,
    output logic      dest_we_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs, rt, rd, sa;
    logic [15:0] imm16;

    alu_op_e   dec_op;
    alu_sel_e  dec_sel;
    logic      dec_we;
    reg_addr_t dec_wd;
    word_t     imm;
    word_t     operand1, operand2;
    logic      cond_ok;

    assign opcode = if_inst_i[31:26];
    assign rs     = if_inst_i[25:21];
    assign rt     = if_inst_i[20:16];
    assign rd     = if_inst_i[15:11];
    assign sa     = if_inst_i[10:6];
    assign funct  = if_inst_i[5:0];
    assign imm16  = if_inst_i[15:0];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    // defaults give a no-op, unknown codes fall through
    always_comb begin
        dec_op      = alu_nop;
        dec_sel     = res_nop;
        dec_we      = 1'b0;
        dec_wd      = rd;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        imm         = '0;
        case (opcode)
            `OP_ORI, `OP_ANDI, `OP_XORI: begin
                dec_sel     = res_logic;
                dec_we      = 1'b1;
                dec_wd      = rt;
                reg1_read_o = 1'b1;
                imm         = {16'h0, imm16};
                case (opcode)
                    `OP_ANDI: dec_op = alu_and;
                    `OP_XORI: dec_op = alu_xor;
                    default:  dec_op = alu_or;
                endcase
            end
            // both operands are the shifted immediate, or of the two
            `OP_LUI: begin
                dec_op  = alu_or;
                dec_sel = res_logic;
                dec_we  = 1'b1;
                dec_wd  = rt;
                imm     = {imm16, 16'h0};
            end
            `OP_SPECIAL: begin
                case (funct)
                    `FN_AND, `FN_OR, `FN_XOR, `FN_NOR: begin
                        dec_sel     = res_logic;
                        dec_we      = 1'b1;
                        reg1_read_o = 1'b1;
                        reg2_read_o = 1'b1;
                        case (funct)
                            `FN_AND: dec_op = alu_and;
                            `FN_XOR: dec_op = alu_xor;
                            `FN_NOR: dec_op = alu_nor;
                            default: dec_op = alu_or;
                        endcase
                    end
                    `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
                        dec_sel     = res_shift;
                        dec_we      = 1'b1;
                        reg2_read_o = 1'b1;
                        // funct[2] set for the variable forms
                        reg1_read_o = funct[2];
                        imm         = {27'h0, sa};
                        case (funct[1:0])
                            2'b10:   dec_op = alu_srl;
                            2'b11:   dec_op = alu_sra;
                            default: dec_op = alu_sll;
                        endcase
                    end
                    `FN_MFHI, `FN_MFLO: begin
                        dec_op  = (funct == `FN_MFHI) ? alu_mfhi : alu_mflo;
                        dec_sel = res_move;
                        dec_we  = 1'b1;
                    end
                    `FN_MTHI, `FN_MTLO: begin
                        dec_op      = (funct == `FN_MTHI) ? alu_mthi : alu_mtlo;
                        reg1_read_o = 1'b1;
                    end
                    `FN_MOVN, `FN_MOVZ: begin
                        dec_op      = (funct == `FN_MOVN) ? alu_movn : alu_movz;
                        dec_sel     = res_move;
                        dec_we      = 1'b1;
                        reg1_read_o = 1'b1;
                        reg2_read_o = 1'b1;
                    end
                    // sync and unknown functions write nothing
                    default: begin
                    end
                endcase
            end
            `OP_PREF: begin
                reg1_read_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ex result first, then mem, then register file, else immediate
    function automatic word_t select_operand(input logic read, input reg_addr_t addr,
                                             input word_t rf_data, input word_t imm_val);
        word_t res;
        if (read && ex_wreg_i && ex_wd_i == addr) begin
            res = ex_wdata_i;
        end else if (read && mem_wreg_i && mem_wd_i == addr) begin
            res = mem_wdata_i;
        end else if (read) begin
            res = rf_data;
        end else begin
            res = imm_val;
        end
        return res;
    endfunction

    assign operand1 = select_operand(reg1_read_o, rs, reg1_data_i, imm);
    assign operand2 = select_operand(reg2_read_o, rt, reg2_data_i, imm);

    // movn/movz test the forwarded rt value
    always_comb begin
        case (dec_op)
            alu_movn: cond_ok = (operand2 != '0);
            alu_movz: cond_ok = (operand2 == '0);
            default:  cond_ok = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_op_o  <= alu_nop;
            alu_sel_o <= res_nop;
            dest_we_o <= 1'b0;
        end else begin
            alu_op_o  <= dec_op;
            alu_sel_o <= dec_sel;
            // r0 target never leaves decode as a write
            dest_we_o <= dec_we && cond_ok && (dec_wd != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        operand1_o  <= operand1;
        operand2_o  <= operand2;
        dest_addr_o <= dec_wd;
    end

endmodule

/* hdl/fetch_stage.sv */
// ******************************
// program counter, fetch port and
// fetch/decode register
// ******************************
module fetch_stage import mips_core_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  inst_t inst_i,
    output logic  inst_ce_o,
    output word_t inst_addr_o,
    output inst_t if_inst_o
);

    // enable comes up one edge after reset is released
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inst_ce_o <= 1'b0;
        end else begin
            inst_ce_o <= 1'b1;
        end
    end

    // pc holds at 0 until the first fetch
    always_ff @(posedge clk_i) begin
        if (!inst_ce_o) begin
            inst_addr_o <= '0;
        end else begin
            inst_addr_o <= inst_addr_o + 32'd4;
        end
    end

    // zero word decodes as sll r0, a bubble
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !inst_ce_o) begin
            if_inst_o <= '0;
        end else begin
            if_inst_o <= inst_i;
        end
    end

endmodule

/* hdl/mips_core_pkg.sv */
// ******************************
// shared vector types and alu
// operation enums of the core
// ******************************
`include "mips_core_config.svh"

package mips_core_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`WORD_W-1:0]     inst_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation subtype, decided in decode
    typedef enum logic [3:0] {
        alu_nop,
        alu_or,
        alu_and,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_mfhi,
        alu_mflo,
        alu_mthi,
        alu_mtlo,
        alu_movn,
        alu_movz
    } alu_op_e;

    // which result the execute stage returns
    typedef enum logic [1:0] {
        res_nop,
        res_logic,
        res_shift,
        res_move
    } alu_sel_e;

endpackage

/* hdl/mips_core_config.svh */
// ******************************
// widths, register count, opcodes
// and function codes of the core
// ******************************
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define REG_NUM     32

// primary opcodes, inst[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_PREF     6'b110011

// special function codes, inst[5:0]
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_MOVZ     6'b001010
`define FN_MOVN     6'b001011
`define FN_SYNC     6'b001111
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111

`endif
